// File: hw/pcxt_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// PC-XT system control shared definitions
// Menu status bit map, clock rates, reset and splash counts, the speed
// encoding, and the packed structs that carry decoded config and SPI
////////////////////////////////////////////////////////////////////////////

package pcxt_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Menu status word
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] status_word_t;

	// Reset
	localparam int STAT_RESET       = 0;
	// Scaler, two bits
	localparam int STAT_SCALE_LO    = 1;
	// Model
	localparam int STAT_MODEL       = 3;
	// MDA
	localparam int STAT_MDA         = 4;
	// Splash
	localparam int STAT_SPLASH_SKIP = 7;
	// Aspect, two bits
	localparam int STAT_ASPECT_LO   = 8;
	// Speed, two bits
	localparam int STAT_SPEED_LO    = 17;
	// Joyswap
	localparam int STAT_JOY_SWAP    = 25;

	////////////////////////////////////////////////////////////////////////////
	// Rates and counts
	////////////////////////////////////////////////////////////////////////////

	// Phase accumulator for fractional strobes
	typedef logic [31:0] acc_t;

	localparam acc_t CLK_HZ    = 32'd50_000_000;
	localparam acc_t SAMPLE_HZ = 32'd44_100;
	localparam acc_t BASE_HZ   = 32'd14_318_180;

	// System reset stretch, in clocks
	localparam int POR_CYCLES      = 65_535;
	// CPU reset trails the system reset by this much
	localparam int CPU_RESET_DELAY = 42;

	localparam int SPLASH_SECONDS       = 5;
	localparam int SPLASH_TICKS_DEFAULT = int'(BASE_HZ);

	// DIP switch bytes, MDA vs CGA 80 columns
	localparam logic [7:0] DIP_CGA = 8'h2D;
	localparam logic [7:0] DIP_MDA = 8'h3D;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	// Encoding matches the menu speed field
	typedef enum logic [1:0] {
		SPEED_4M77 = 2'd0,
		SPEED_7M16 = 2'd1,
		SPEED_14M3 = 2'd2,
		SPEED_RSVD = 2'd3
	} cpu_speed_e;

	typedef logic [12:0] aspect_t;
	typedef logic [31:0] joy_t;
	typedef logic [15:0] joya_t;

	typedef struct packed {
		logic [1:0] scale;
		logic       model;
		logic       mda;
		logic [1:0] aspect;
		cpu_speed_e speed;
		logic       joy_swap;
	} board_cfg_t;

	// Same layout for controller, card and virtual card sides
	typedef struct packed {
		logic cs;
		logic sck;
		logic mosi;
	} spi_bus_t;

endpackage

// File: hw/rate_strobe_gen.sv
////////////////////////////////////////////////////////////////////////////
// Fractional rate strobe generator
// One-cycle strobes at an average of STEP per MODULUS clocks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rate_strobe_gen import pcxt_ctrl_pkg::*; #(
	parameter acc_t STEP    = SAMPLE_HZ,
	parameter acc_t MODULUS = CLK_HZ
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic strobe
);

	acc_t acc;
	acc_t acc_next;

	// Sum before the wrap test
	assign acc_next = acc + STEP;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc    <= '0;
			strobe <= 1'b0;
		end else if (acc_next >= MODULUS) begin
			// Crossed a period boundary, keep the remainder
			acc    <= acc_next - MODULUS;
			strobe <= 1'b1;
		end else begin
			acc    <= acc_next;
			strobe <= 1'b0;
		end
	end

	// Remainder always stays inside one period
	a_acc_range: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		acc < MODULUS);

endmodule

// File: hw/cpu_clock_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// CPU and peripheral clock enables
// Divides the 14.318 MHz base enable, selects the CPU rate from the menu
// speed and latches the turbo flag on the bus-idle pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cpu_clock_ctrl import pcxt_ctrl_pkg::*; (
	input  logic       CLK_50M,
	input  logic       reset_wire,
	input  logic       base_ce,
	input  board_cfg_t cfg,
	input  logic       biu_done,
	output logic       cpu_ce,
	output logic       periph_ce,
	output logic       turbo
);

	logic       div2;
	logic [1:0] div3;
	logic       ptog;
	logic       ce_7m16;
	logic       ce_4m77;

	////////////////////////////////////////////////////////////////////////////
	// Dividers, all advance on base_ce only
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			div2 <= 1'b0;
			div3 <= 2'd0;
		end else if (base_ce) begin
			div2 <= ~div2;
			// Mod-3 count
			div3 <= (div3 == 2'd2) ? 2'd0 : div3 + 2'd1;
		end
	end

	// 7.16 MHz, every second base strobe
	assign ce_7m16 = base_ce & div2;
	// 4.77 MHz, every third
	assign ce_4m77 = base_ce & (div3 == 2'd2);

	// Peripheral toggle at half the 4.77 rate
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			ptog <= 1'b0;
		else if (ce_4m77)
			ptog <= ~ptog;
	end

	assign periph_ce = ce_4m77 & ptog;

	////////////////////////////////////////////////////////////////////////////
	// Speed select and turbo
	////////////////////////////////////////////////////////////////////////////

	// Combinational pick, new speed shows up within one base period
	always_comb begin
		case (cfg.speed)
			SPEED_14M3: cpu_ce = base_ce;
			SPEED_7M16: cpu_ce = ce_7m16;
			// Reserved runs as stock XT
			default:    cpu_ce = ce_4m77;
		endcase
	end

	// Turbo only changes between bus cycles
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			turbo <= 1'b0;
		else if (biu_done)
			turbo <= (cfg.speed == SPEED_7M16) || (cfg.speed == SPEED_14M3);
	end

	a_cpu_ce_on_base: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		cpu_ce |-> base_ce);

endmodule

// File: hw/reset_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Reset sequencing
// Stretches the system reset, releases the CPU reset a little later and
// captures the machine model while the system is held
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module reset_sequencer import pcxt_ctrl_pkg::*; (
	input  logic       CLK_50M,
	input  logic       reset_wire,
	input  logic       reset_request,
	input  board_cfg_t cfg,
	output logic       sys_reset,
	output logic       cpu_reset,
	output logic       model
);

	localparam int DELAY_W = $clog2(CPU_RESET_DELAY + 1);

	logic [15:0]        por_cnt;
	logic [DELAY_W-1:0] delay_cnt;

	////////////////////////////////////////////////////////////////////////////
	// System reset stretch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset <= 1'b1;
			por_cnt   <= '0;
		end else if (reset_request) begin
			// Any request restarts the stretch
			sys_reset <= 1'b1;
			por_cnt   <= '0;
		end else if (sys_reset) begin
			if (por_cnt != 16'(POR_CYCLES))
				por_cnt <= por_cnt + 16'd1;
			else
				sys_reset <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// CPU reset delay
	////////////////////////////////////////////////////////////////////////////

	// Request also sets cpu_reset so it rises together with sys_reset
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset <= 1'b1;
			delay_cnt <= '0;
		end else if (sys_reset || reset_request) begin
			cpu_reset <= 1'b1;
			delay_cnt <= '0;
		end else if (cpu_reset) begin
			if (delay_cnt != DELAY_W'(CPU_RESET_DELAY))
				delay_cnt <= delay_cnt + 1'b1;
			else
				cpu_reset <= 1'b0;
		end
	end

	// Model follows the menu only while held in reset
	always_ff @(posedge CLK_50M) begin
		if (sys_reset)
			model <= cfg.model;
	end

	a_cpu_after_sys: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> cpu_reset);

endmodule

// File: hw/splash_timer.sv
////////////////////////////////////////////////////////////////////////////
// Splash screen timer
// Holds the machine for a few seconds of base strobes unless skipped
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module splash_timer import pcxt_ctrl_pkg::*; #(
	parameter int TICKS_PER_SECOND = SPLASH_TICKS_DEFAULT
) (
	input  logic       CLK_50M,
	input  logic       reset_wire,
	input  logic       base_ce,
	input  board_cfg_t cfg,
	input  logic       skip,
	output logic       splash_active
);

	localparam int TICK_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;
	localparam int SEC_W  = $clog2(SPLASH_SECONDS + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic [SEC_W-1:0]  sec_cnt;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (skip) begin
				splash_active <= 1'b0;
			end else if (base_ce) begin
				if (tick_cnt == TICK_W'(TICKS_PER_SECOND - 1)) begin
					// One second elapsed
					tick_cnt <= '0;
					if (sec_cnt == SEC_W'(SPLASH_SECONDS - 1))
						splash_active <= 1'b0;
					else
						sec_cnt <= sec_cnt + 1'b1;
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
		end
	end

	// Menu state must be settled while the splash decides the reset
	a_menu_known: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		splash_active |-> !$isunknown({skip, cfg}));

endmodule

// File: hw/board_config.sv
////////////////////////////////////////////////////////////////////////////
// Menu status decode
// Video aspect, scaler, DIP switch and joystick routing from the status word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module board_config import pcxt_ctrl_pkg::*; (
	input  status_word_t status,
	input  logic         port_b_bit3,
	input  joy_t         joy0_in,
	input  joy_t         joy1_in,
	input  joya_t        joya0_in,
	input  joya_t        joya1_in,
	output board_cfg_t   cfg,
	output aspect_t      video_arx,
	output aspect_t      video_ary,
	output logic [1:0]   vga_sl,
	output logic         scandoubler,
	output logic         hq2x,
	output logic [3:0]   port_c_low,
	output joy_t         joy0,
	output joy_t         joy1,
	output joya_t        joya0,
	output joya_t        joya1
);

	logic [7:0] dip_sw;
	logic [1:0] aspect_m1;

	////////////////////////////////////////////////////////////////////////////
	// Field extraction
	////////////////////////////////////////////////////////////////////////////

	assign cfg.scale    = status[STAT_SCALE_LO +: 2];
	assign cfg.model    = status[STAT_MODEL];
	assign cfg.mda      = status[STAT_MDA];
	assign cfg.aspect   = status[STAT_ASPECT_LO +: 2];
	assign cfg.speed    = cpu_speed_e'(status[STAT_SPEED_LO +: 2]);
	assign cfg.joy_swap = status[STAT_JOY_SWAP];

	////////////////////////////////////////////////////////////////////////////
	// Video
	////////////////////////////////////////////////////////////////////////////

	// Aspect 0 is native 4:3, others select ARC slots
	assign aspect_m1 = cfg.aspect - 2'd1;
	assign video_arx = (cfg.aspect == 2'd0) ? aspect_t'(4) : aspect_t'(aspect_m1);
	assign video_ary = (cfg.aspect == 2'd0) ? aspect_t'(3) : aspect_t'(0);

	// CRT 50% on top bit, CRT 25% on low bit
	assign vga_sl      = {cfg.scale == 2'd3, cfg.scale == 2'd2};
	assign scandoubler = (cfg.scale != 2'd0);
	assign hq2x        = (cfg.scale == 2'd1);

	////////////////////////////////////////////////////////////////////////////
	// DIP switches and joysticks
	////////////////////////////////////////////////////////////////////////////

	assign dip_sw = cfg.mda ? DIP_MDA : DIP_CGA;

	// Port B bit 3 picks which nibble the BIOS reads
	assign port_c_low = port_b_bit3 ? dip_sw[7:4] : dip_sw[3:0];

	// Digital and analog swap together
	assign joy0  = cfg.joy_swap ? joy1_in : joy0_in;
	assign joy1  = cfg.joy_swap ? joy0_in : joy1_in;
	assign joya0 = cfg.joy_swap ? joya1_in : joya0_in;
	assign joya1 = cfg.joy_swap ? joya0_in : joya1_in;

endmodule

// File: hw/sd_spi_mux.sv
////////////////////////////////////////////////////////////////////////////
// SD SPI multiplexer
// Routes the controller SPI to the physical or the virtual card
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sd_spi_mux import pcxt_ctrl_pkg::*; (
	input  logic        CLK_50M,
	input  logic        reset_wire,
	input  logic        img_mounted,
	input  logic [63:0] img_size,
	input  spi_bus_t    ctrl_spi,
	input  logic        sd_miso,
	input  logic        vsd_miso,
	output spi_bus_t    sd_spi,
	output spi_bus_t    vsd_spi,
	output logic        ctrl_miso,
	output logic        vsd_sel
);

	// Nonzero image means virtual card, empty mount goes back to the slot
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire)
			vsd_sel <= 1'b0;
		else if (img_mounted)
			vsd_sel <= |img_size;
	end

	// Physical card, deselected and quiet when virtual is active
	assign sd_spi.cs   = ctrl_spi.cs | vsd_sel;
	assign sd_spi.sck  = ctrl_spi.sck & ~vsd_sel;
	assign sd_spi.mosi = ctrl_spi.mosi & ~vsd_sel;

	// Virtual card
	assign vsd_spi.cs   = ctrl_spi.cs | ~vsd_sel;
	assign vsd_spi.sck  = ctrl_spi.sck;
	assign vsd_spi.mosi = ctrl_spi.mosi;

	assign ctrl_miso = vsd_sel ? vsd_miso : sd_miso;

	a_one_card: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		sd_spi.cs || vsd_spi.cs);

endmodule

// File: hw/pcxt_ctrl_top.sv
////////////////////////////////////////////////////////////////////////////
// PC-XT system control top level
// Clock enables, reset sequencing, splash, menu decode and SD routing
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pcxt_ctrl_top import pcxt_ctrl_pkg::*; #(
	parameter int SPLASH_TICKS = SPLASH_TICKS_DEFAULT
) (
	input  logic         CLK_50M,
	input  logic         reset_wire,
	input  status_word_t status,
	input  logic         user_button,
	input  logic         biu_done,
	input  logic         port_b_bit3,
	input  joy_t         joy0_in,
	input  joy_t         joy1_in,
	input  joya_t        joya0_in,
	input  joya_t        joya1_in,
	input  logic         img_mounted,
	input  logic [63:0]  img_size,
	input  spi_bus_t     ctrl_spi,
	input  logic         sd_miso,
	input  logic         vsd_miso,
	output logic         sample_ce,
	output logic         cpu_ce,
	output logic         periph_ce,
	output logic         turbo,
	output logic         sys_reset,
	output logic         cpu_reset,
	output logic         model,
	output logic         splash_active,
	output aspect_t      video_arx,
	output aspect_t      video_ary,
	output logic [1:0]   vga_sl,
	output logic         scandoubler,
	output logic         hq2x,
	output logic [3:0]   port_c_low,
	output joy_t         joy0,
	output joy_t         joy1,
	output joya_t        joya0,
	output joya_t        joya1,
	output spi_bus_t     sd_spi,
	output spi_bus_t     vsd_spi,
	output logic         ctrl_miso,
	output logic         vsd_sel
);

	board_cfg_t cfg;
	logic       base_ce;
	logic       reset_request;

	////////////////////////////////////////////////////////////////////////////
	// Clock enables
	////////////////////////////////////////////////////////////////////////////

	// 44.1 kHz audio sample enable
	rate_strobe_gen #(.STEP(SAMPLE_HZ), .MODULUS(CLK_HZ)) u_sample_gen (
		.CLK_50M(CLK_50M), .reset_wire(reset_wire), .strobe(sample_ce)
	);

	// 14.318 MHz base enable
	rate_strobe_gen #(.STEP(BASE_HZ), .MODULUS(CLK_HZ)) u_base_gen (
		.CLK_50M(CLK_50M), .reset_wire(reset_wire), .strobe(base_ce)
	);

	cpu_clock_ctrl u_clk (
		.CLK_50M(CLK_50M), .reset_wire(reset_wire), .base_ce(base_ce), .cfg(cfg),
		.biu_done(biu_done), .cpu_ce(cpu_ce), .periph_ce(periph_ce), .turbo(turbo)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reset and splash
	////////////////////////////////////////////////////////////////////////////

	// Menu reset, user button, or splash still showing
	assign reset_request = status[STAT_RESET] | user_button | splash_active;

	reset_sequencer u_rst (
		.CLK_50M(CLK_50M), .reset_wire(reset_wire), .reset_request(reset_request),
		.cfg(cfg), .sys_reset(sys_reset), .cpu_reset(cpu_reset), .model(model)
	);

	splash_timer #(.TICKS_PER_SECOND(SPLASH_TICKS)) u_splash (
		.CLK_50M(CLK_50M), .reset_wire(reset_wire), .base_ce(base_ce), .cfg(cfg),
		.skip(status[STAT_SPLASH_SKIP]), .splash_active(splash_active)
	);

	////////////////////////////////////////////////////////////////////////////
	// Config decode and SD
	////////////////////////////////////////////////////////////////////////////

	board_config u_cfg (
		.status(status), .port_b_bit3(port_b_bit3),
		.joy0_in(joy0_in), .joy1_in(joy1_in), .joya0_in(joya0_in), .joya1_in(joya1_in),
		.cfg(cfg), .video_arx(video_arx), .video_ary(video_ary), .vga_sl(vga_sl),
		.scandoubler(scandoubler), .hq2x(hq2x), .port_c_low(port_c_low),
		.joy0(joy0), .joy1(joy1), .joya0(joya0), .joya1(joya1)
	);

	sd_spi_mux u_sd (
		.CLK_50M(CLK_50M), .reset_wire(reset_wire), .img_mounted(img_mounted),
		.img_size(img_size), .ctrl_spi(ctrl_spi), .sd_miso(sd_miso),
		.vsd_miso(vsd_miso), .sd_spi(sd_spi), .vsd_spi(vsd_spi),
		.ctrl_miso(ctrl_miso), .vsd_sel(vsd_sel)
	);

endmodule

// File: verif/tb_pcxt_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// PC-XT system control testbench
// Splash and reset timing, enable rates, turbo, menu decode, joystick swap
// and SD card routing, all checked against expected values
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_pcxt_ctrl import pcxt_ctrl_pkg::*;;

	// Short splash second keeps the run small
	localparam int     TICKS_TB  = 100;
	localparam int     WINDOW    = 50_000;
	localparam longint SYS_HZ    = 50_000_000;
	localparam longint SMP_RATE  = 44_100;
	localparam longint BASE_RATE = 14_318_180;

	logic         CLK_50M = 1'b0;
	logic         reset_wire;
	status_word_t status;
	logic         user_button;
	logic         biu_done;
	logic         port_b_bit3;
	joy_t         joy0_in, joy1_in;
	joya_t        joya0_in, joya1_in;
	logic         img_mounted;
	logic [63:0]  img_size;
	spi_bus_t     ctrl_spi;
	logic         sd_miso, vsd_miso;
	logic         sample_ce, cpu_ce, periph_ce, turbo;
	logic         sys_reset, cpu_reset, model, splash_active;
	aspect_t      video_arx, video_ary;
	logic [1:0]   vga_sl;
	logic         scandoubler, hq2x;
	logic [3:0]   port_c_low;
	joy_t         joy0, joy1;
	joya_t        joya0, joya1;
	spi_bus_t     sd_spi, vsd_spi;
	logic         ctrl_miso, vsd_sel;

	// Expected decode, row i serves aspect i, scale i and {mda, port_b_bit3} = i
	typedef struct packed {
		aspect_t    arx;
		aspect_t    ary;
		logic [1:0] sl;
		logic       sd;
		logic       hq;
		logic [3:0] port_c;
	} dec_row_t;

	dec_row_t    dec_tab [4];
	logic [31:0] lfsr_state = 32'h9823a571;

	pcxt_ctrl_top #(.SPLASH_TICKS(TICKS_TB)) DUT (.*);

	// 50 MHz
	always #10 CLK_50M = ~CLK_50M;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first failure");
	endtask

	// Exact match unless a tolerance is given
	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp,
			input int tol = 0);
		logic [63:0] diff;
		diff = (got > exp) ? got - exp : exp - got;
		// Unknown bits never count as a match
		if ($isunknown(got) || diff > 64'(tol)) begin
			$display("[ERROR] t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Right-shift Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			0:       return splash_active;
			1:       return sys_reset;
			default: return cpu_reset;
		endcase
	endfunction

	// Counts negedges until the signal is low, base strobes seen while high
	task automatic wait_low(input string name, input int sel, input int limit,
			output int cycles, output int bases);
		cycles = 0;
		bases  = 0;
		while (1) begin
			@(negedge CLK_50M);
			cycles++;
			if (!probe(sel))
				break;
			if (DUT.base_ce)
				bases++;
			if (cycles >= limit) begin
				$display("Timeout: %s still high after %0d cycles", name, limit);
				abort_run();
			end
		end
	endtask

	// Caller sits on a rising edge
	task automatic apply_reset();
		reset_wire <= 1'b1;
		repeat (5) @(posedge CLK_50M);
		reset_wire <= 1'b0;
	endtask

	// First negedge still shows the state before the window
	task automatic measure(input int n, output int n_smp, output int n_base,
			output int n_cpu, output int n_per);
		n_smp  = 0;
		n_base = 0;
		n_cpu  = 0;
		n_per  = 0;
		@(negedge CLK_50M);
		repeat (n) begin
			@(negedge CLK_50M);
			if (sample_ce)
				n_smp++;
			if (DUT.base_ce)
				n_base++;
			if (cpu_ce)
				n_cpu++;
			if (periph_ce)
				n_per++;
		end
	endtask

	// Mount an image, then random SPI traffic against the routing rule
	task automatic mount_and_route(input logic [63:0] size);
		logic        sel;
		logic [63:0] r;
		sel = |size;
		@(posedge CLK_50M);
		img_size    <= size;
		img_mounted <= 1'b1;
		@(posedge CLK_50M);
		img_mounted <= 1'b0;
		@(negedge CLK_50M);
		check("vsd_sel", 64'(vsd_sel), 64'(sel));
		repeat (8) begin
			take_bits(5, r);
			@(posedge CLK_50M);
			ctrl_spi <= r[2:0];
			sd_miso  <= r[3];
			vsd_miso <= r[4];
			@(negedge CLK_50M);
			check("sd_spi", 64'(sd_spi), sel ? 64'(3'b100) : 64'(r[2:0]));
			check("vsd_spi", 64'(vsd_spi), sel ? 64'(r[2:0]) : 64'({1'b1, r[1:0]}));
			check("ctrl_miso", 64'(ctrl_miso), sel ? 64'(r[4]) : 64'(r[3]));
			check("sd/vsd cs never both low", 64'(sd_spi.cs | vsd_spi.cs), 64'(1));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		status_word_t st;
		int           n, bases, n_smp, n_base, n_cpu, n_per, div;
		logic         turbo_exp;
		logic [63:0]  r0, r1, r2;

		dec_tab[0] = '{13'd4, 13'd3, 2'b00, 1'b0, 1'b0, 4'hD};
		dec_tab[1] = '{13'd0, 13'd0, 2'b00, 1'b1, 1'b1, 4'h2};
		dec_tab[2] = '{13'd1, 13'd0, 2'b01, 1'b1, 1'b0, 4'hD};
		dec_tab[3] = '{13'd2, 13'd0, 2'b10, 1'b1, 1'b0, 4'h3};

		// Model bit set, no skip, stock speed
		st = '0;
		st[STAT_MODEL] = 1'b1;
		status      <= st;
		user_button <= 1'b0;
		biu_done    <= 1'b0;
		port_b_bit3 <= 1'b0;
		joy0_in     <= '0;
		joy1_in     <= '0;
		joya0_in    <= '0;
		joya1_in    <= '0;
		img_mounted <= 1'b0;
		img_size    <= '0;
		ctrl_spi    <= 3'b100;
		sd_miso     <= 1'b0;
		vsd_miso    <= 1'b0;
		apply_reset();

		// Full splash, then the two reset releases
		wait_low("splash_active", 0, 5000, n, bases);
		check("splash base_ce count", 64'(bases), 64'(SPLASH_SECONDS * TICKS_TB));
		wait_low("sys_reset", 1, POR_CYCLES + 100, n, bases);
		check("sys_reset release cycles", 64'(n), 64'(POR_CYCLES + 1));
		wait_low("cpu_reset", 2, 100, n, bases);
		check("cpu_reset release cycles", 64'(n), 64'(CPU_RESET_DELAY + 1));
		check("model", 64'(model), 64'(1));
		@(posedge CLK_50M);
		st[STAT_MODEL] = 1'b0;
		status <= st;
		repeat (3) @(negedge CLK_50M);
		check("model held", 64'(model), 64'(1));

		// Skip ends the splash on the first working edge
		@(posedge CLK_50M);
		st[STAT_SPLASH_SKIP] = 1'b1;
		status <= st;
		apply_reset();
		wait_low("splash_active", 0, 10, n, bases);
		check("splash cycles with skip", 64'(n), 64'(2));

		// Rates per speed, turbo only moves on biu_done
		turbo_exp = 1'b0;
		for (int k = 0; k < 4; k++) begin
			@(posedge CLK_50M);
			st[STAT_SPEED_LO +: 2] = 2'(k);
			status <= st;
			if (k == 0)
				apply_reset();
			measure(WINDOW, n_smp, n_base, n_cpu, n_per);
			if (k == 0) begin
				check("sample_ce count", 64'(n_smp), 64'(longint'(WINDOW) * SMP_RATE / SYS_HZ));
				check("base_ce count", 64'(n_base), 64'(longint'(WINDOW) * BASE_RATE / SYS_HZ));
			end
			// 14.3 runs every base strobe, 7.16 every second, others every third
			div = (k == 2) ? 1 : (k == 1) ? 2 : 3;
			check("cpu_ce count", 64'(n_cpu), 64'(n_base / div), 1);
			check("periph_ce count", 64'(n_per), 64'(n_base / 6), 1);
			check("turbo before biu_done", 64'(turbo), 64'(turbo_exp));
			@(posedge CLK_50M);
			biu_done <= 1'b1;
			@(posedge CLK_50M);
			biu_done <= 1'b0;
			@(negedge CLK_50M);
			turbo_exp = (k == 1) || (k == 2);
			check("turbo after biu_done", 64'(turbo), 64'(turbo_exp));
		end

		// Every aspect, scale, mda and nibble select
		st[STAT_SPEED_LO +: 2] = 2'd0;
		for (int a = 0; a < 4; a++) begin
			for (int s = 0; s < 4; s++) begin
				for (int d = 0; d < 4; d++) begin
					@(posedge CLK_50M);
					st[STAT_ASPECT_LO +: 2] = 2'(a);
					st[STAT_SCALE_LO +: 2]  = 2'(s);
					st[STAT_MDA]            = d[1];
					status      <= st;
					port_b_bit3 <= d[0];
					@(negedge CLK_50M);
					check("video_arx", 64'(video_arx), 64'(dec_tab[a].arx));
					check("video_ary", 64'(video_ary), 64'(dec_tab[a].ary));
					check("vga_sl", 64'(vga_sl), 64'(dec_tab[s].sl));
					check("scandoubler", 64'(scandoubler), 64'(dec_tab[s].sd));
					check("hq2x", 64'(hq2x), 64'(dec_tab[s].hq));
					check("port_c_low", 64'(port_c_low), 64'(dec_tab[d].port_c));
				end
			end
		end

		// Joystick pairs, swap on odd passes
		for (int i = 0; i < 8; i++) begin
			take_bits(32, r0);
			take_bits(32, r1);
			take_bits(32, r2);
			@(posedge CLK_50M);
			st[STAT_JOY_SWAP] = i[0];
			status   <= st;
			joy0_in  <= r0[31:0];
			joy1_in  <= r1[31:0];
			joya0_in <= r2[15:0];
			joya1_in <= r2[31:16];
			@(negedge CLK_50M);
			check("joy0", 64'(joy0), i[0] ? r1 : r0);
			check("joy1", 64'(joy1), i[0] ? r0 : r1);
			check("joya0", 64'(joya0), i[0] ? 64'(r2[31:16]) : 64'(r2[15:0]));
			check("joya1", 64'(joya1), i[0] ? 64'(r2[15:0]) : 64'(r2[31:16]));
		end

		// Virtual card, back to the slot, virtual again
		take_bits(64, r0);
		mount_and_route((r0 == '0) ? 64'd1 : r0);
		mount_and_route('0);
		take_bits(64, r1);
		mount_and_route(r1 | 64'd1);

		// User button restarts reset and recaptures the model
		@(posedge CLK_50M);
		st[STAT_MODEL] = 1'b1;
		status <= st;
		@(negedge CLK_50M);
		check("model held", 64'(model), 64'(0));
		@(posedge CLK_50M);
		user_button <= 1'b1;
		@(posedge CLK_50M);
		user_button <= 1'b0;
		@(negedge CLK_50M);
		check("sys_reset after button", 64'(sys_reset), 64'(1));
		check("cpu_reset after button", 64'(cpu_reset), 64'(1));
		@(negedge CLK_50M);
		check("model captured", 64'(model), 64'(1));

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: sim.f
hw/pcxt_ctrl_pkg.sv
hw/rate_strobe_gen.sv
hw/cpu_clock_ctrl.sv
hw/reset_sequencer.sv
hw/splash_timer.sv
hw/board_config.sv
hw/sd_spi_mux.sv
hw/pcxt_ctrl_top.sv
verif/tb_pcxt_ctrl.sv

// File: Makefile
# Verilator build and run for the PC-XT system control block

VERILATOR  ?= verilator
TOP        ?= tb_pcxt_ctrl
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Result comes from the log, not the exit code of the pipe
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
